/* build.sh */
#!/bin/sh
# Compiles the testbench and the design with Verilator, then runs the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_ps2_keyboard \
    -Mdir obj_dir \
    -f ps2_keyboard.f

./obj_dir/Vtb_ps2_keyboard > sim.log 2>&1
cat sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1

/* logic/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     raw_mode,
    input  logic                     key_ack,
    scan_byte_if.decoder             bytes,
    output logic                     key_pending,
    output key_event_pkg::key_code_t key_code,
    output logic                     key_extended,
    output logic                     key_released
);
    import ps2_line_pkg::*;
    import key_event_pkg::*;

    ps2_byte_t head_byte;
    logic      take_byte;
    logic      is_prefix;
    logic      extended_flag;
    logic      released_flag;

    assign head_byte = bytes.pop_data;

    // Pull a byte whenever the host has taken the last event
    assign take_byte = !key_pending && !bytes.empty;
    assign bytes.pop = take_byte;

    // Prefixes only mean something to a keyboard
    assign is_prefix = !raw_mode &&
                       ((head_byte == PREFIX_EXTENDED) || (head_byte == PREFIX_RELEASE));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_pending   <= 1'b0;
            extended_flag <= 1'b0;
            released_flag <= 1'b0;
        end else begin
            if (key_ack) begin
                key_pending <= 1'b0;
            end
            if (take_byte) begin
                if (raw_mode) begin
                    key_pending   <= 1'b1;
                    extended_flag <= 1'b0;
                    released_flag <= 1'b0;
                end else if (head_byte == PREFIX_EXTENDED) begin
                    extended_flag <= 1'b1;
                end else if (head_byte == PREFIX_RELEASE) begin
                    released_flag <= 1'b1;
                end else begin
                    // Key code closes the sequence, prefixes start over
                    key_pending   <= 1'b1;
                    extended_flag <= 1'b0;
                    released_flag <= 1'b0;
                end
            end
        end
    end

    // Event outputs are captured together with key_pending and held
    // until the next event replaces them
    always_ff @(posedge clk) begin
        if (take_byte && !is_prefix) begin
            key_code     <= head_byte;
            key_extended <= extended_flag && !raw_mode;
            key_released <= released_flag && !raw_mode;
        end
    end

endmodule

/* logic/key_event_pkg.sv */
package key_event_pkg;

    // Key code as handed to the host, scan code set 2
    typedef logic [7:0] key_code_t;

    // Prefix sent before the code of an extended key such as the arrows
    localparam key_code_t PREFIX_EXTENDED = 8'hE0;

    // Prefix sent before the code of a key that was let go
    localparam key_code_t PREFIX_RELEASE = 8'hF0;

    // A released extended key arrives as E0 F0 code, so both prefixes
    // may stack in front of one key code

endpackage

/* logic/ps2_keyboard.sv */
`timescale 1ns/1ps

module ps2_keyboard #(
    parameter ps2_line_pkg::timeout_count_t TIMEOUT_CYCLES = 24'hFFFFFF,
    parameter int                           FIFO_DEPTH     = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rx_enable,
    input  logic                     raw_mode,
    input  logic                     key_ack,
    input  logic                     ps2_clk,
    input  logic                     ps2_data,
    output logic                     key_pending,
    output key_event_pkg::key_code_t key_code,
    output logic                     key_extended,
    output logic                     key_released,
    output logic                     overflow
);

    // Byte path from the line receiver through the FIFO to the decoder
    scan_byte_if scan_bytes ();

    ps2_receiver #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) ps2_receiver_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_enable (rx_enable),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .bytes     (scan_bytes.receiver)
    );

    // Absorbs typematic bursts while the host is slow to acknowledge
    scan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) scan_fifo_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .bytes    (scan_bytes.fifo),
        .overflow (overflow)
    );

    key_decoder key_decoder_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .raw_mode     (raw_mode),
        .key_ack      (key_ack),
        .bytes        (scan_bytes.decoder),
        .key_pending  (key_pending),
        .key_code     (key_code),
        .key_extended (key_extended),
        .key_released (key_released)
    );

endmodule

/* logic/ps2_line_pkg.sv */
package ps2_line_pkg;

    // One data byte as it is framed on the PS/2 line, LSB first
    typedef logic [7:0] ps2_byte_t;

    // Counts system clock cycles while the line shows no clock edge
    typedef logic [23:0] timeout_count_t;

    // Depth of the PS/2 clock glitch filter in samples
    localparam int EDGE_HISTORY = 16;

    typedef logic [EDGE_HISTORY-1:0] edge_history_t;

    // A falling edge is taken as real only after three quarters of the
    // history were high and the newest quarter is low
    localparam edge_history_t FALL_PATTERN = {
        {(EDGE_HISTORY * 3 / 4){1'b1}},
        {(EDGE_HISTORY / 4){1'b0}}
    };

    // Frame receiver states, one per field of the frame
    typedef enum logic [1:0] {
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_e;

endpackage

/* logic/ps2_receiver.sv */
`timescale 1ns/1ps

module ps2_receiver #(
    parameter ps2_line_pkg::timeout_count_t TIMEOUT_CYCLES = 24'hFFFFFF
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          rx_enable,
    input  logic          ps2_clk,
    input  logic          ps2_data,
    scan_byte_if.receiver bytes
);
    import ps2_line_pkg::*;

    logic [1:0]     clk_sync;
    logic [1:0]     data_sync;
    edge_history_t  clk_history;
    logic           fall_edge;
    logic           rx_tick;
    logic           line_data;
    rx_state_e      state;
    ps2_byte_t      shift_q;
    timeout_count_t idle_count;
    logic           push_q;

    // Both pins are asynchronous to clk and idle high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign line_data = data_sync[1];

    // Newest sample enters at bit 0, so the oldest sits at the top
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_history <= '1;
        end else begin
            clk_history <= {clk_history[EDGE_HISTORY-2:0], clk_sync[1]};
        end
    end

    // The pattern holds for exactly one cycle per clean falling edge
    assign fall_edge = (clk_history == FALL_PATTERN);
    assign rx_tick   = fall_edge && rx_enable;

    // Frame state machine and the stall timeout
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= rx_start;
            idle_count <= '0;
            push_q     <= 1'b0;
        end else begin
            push_q <= 1'b0;
            if (rx_tick) begin
                idle_count <= '0;
                case (state)
                    rx_start: begin
                        if (!line_data) begin
                            state <= rx_data;
                        end
                    end
                    rx_data: begin
                        // Marker bit has reached bit 0, this is the eighth data bit
                        if (shift_q[0]) begin
                            state <= rx_parity;
                        end
                    end
                    rx_parity: begin
                        // Data plus parity must hold an odd number of ones
                        if (^{shift_q, line_data}) begin
                            state <= rx_stop;
                        end else begin
                            state <= rx_start;
                        end
                    end
                    rx_stop: begin
                        state  <= rx_start;
                        push_q <= line_data;
                    end
                    default: begin
                        state <= rx_start;
                    end
                endcase
            end else if (idle_count == TIMEOUT_CYCLES) begin
                // Device went quiet in the middle of a frame
                idle_count <= '0;
                state      <= rx_start;
            end else begin
                idle_count <= idle_count + 1'b1;
            end
        end
    end

    // Shift register, loaded with a marker at the start bit. Its
    // contents stay put from the stop bit until the next start bit
    always_ff @(posedge clk) begin
        if (rx_tick) begin
            if (state == rx_start) begin
                shift_q <= 8'h80;
            end else if (state == rx_data) begin
                shift_q <= {line_data, shift_q[7:1]};
            end
        end
    end

    assign bytes.push      = push_q;
    assign bytes.push_data = shift_q;

endmodule

/* logic/scan_byte_if.sv */
`timescale 1ns/1ps

interface scan_byte_if;
    import ps2_line_pkg::*;

    // Write side, one strobe per received byte
    logic      push;
    ps2_byte_t push_data;

    // Read side, first word fall through
    logic      pop;
    ps2_byte_t pop_data;
    logic      empty;

    modport receiver (
        output push,
        output push_data
    );

    modport fifo (
        input  push,
        input  push_data,
        input  pop,
        output pop_data,
        output empty
    );

    modport decoder (
        input  pop_data,
        input  empty,
        output pop
    );

endinterface

/* logic/scan_fifo.sv */
`timescale 1ns/1ps

module scan_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    scan_byte_if.fifo bytes,
    output logic      overflow
);
    import ps2_line_pkg::*;

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    ps2_byte_t           mem [FIFO_DEPTH];
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                full;
    logic                empty;
    logic                do_push;
    logic                do_pop;

    // The extra pointer bit tells a full buffer from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign do_pop  = bytes.pop && !empty;
    // A pop in the same cycle frees the slot for the incoming byte
    assign do_push = bytes.push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= bytes.push_data;
        end
    end

    // Sticky until reset so the host can notice lost keystrokes late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (bytes.push && !do_push) begin
            overflow <= 1'b1;
        end
    end

    // Head entry is always visible while the buffer holds data
    assign bytes.pop_data = mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign bytes.empty    = empty;

endmodule

/* ps2_keyboard.f */
logic/ps2_line_pkg.sv
logic/key_event_pkg.sv
logic/scan_byte_if.sv
logic/ps2_receiver.sv
logic/scan_fifo.sv
logic/key_decoder.sv
logic/ps2_keyboard.sv
sim/tb_ps2_keyboard.sv

/* sim/tb_ps2_keyboard.sv */
`timescale 1ns/1ps

module tb_ps2_keyboard;
    import ps2_line_pkg::*;
    import key_event_pkg::*;

    localparam timeout_count_t TIMEOUT_CYCLES = 24'd2000;
    localparam int FIFO_DEPTH    = 4;
    localparam int HALF_BIT      = 40;
    localparam int EVENT_TIMEOUT = 4000;
    localparam int HOLD_CYCLES   = 50;

    // Kinds of frame damage used in the table
    localparam int OK_FRAME   = 0;
    localparam int BAD_PARITY = 1;
    localparam int BAD_STOP   = 2;
    localparam int TRUNCATED  = 3;

    typedef struct packed {
        key_code_t [2:0] seq;
        logic [1:0]      nbytes;
        logic            bad_parity;
        logic            bad_stop;
        logic [3:0]      frame_bits;
        logic            raw;
        logic            hold;
        logic            has_event;
        key_code_t       exp_code;
        logic            exp_ext;
        logic            exp_rel;
    } stim_t;

    logic      clk;
    logic      rst_n;
    logic      rx_enable;
    logic      raw_mode;
    logic      key_ack;
    logic      ps2_clk;
    logic      ps2_data;
    logic      key_pending;
    key_code_t key_code;
    logic      key_extended;
    logic      key_released;
    logic      overflow;

    stim_t  stim_table[$];
    stim_t  held_rows[$];
    integer seed;
    int     value_errors;
    int     event_errors;

    ps2_keyboard #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) ps2_keyboard_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_enable    (rx_enable),
        .raw_mode     (raw_mode),
        .key_ack      (key_ack),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_pending  (key_pending),
        .key_code     (key_code),
        .key_extended (key_extended),
        .key_released (key_released),
        .overflow     (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Leaves the caller 1 ns after a rising edge, where inputs change and outputs are stable
    task automatic step(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_code(input string name, input key_code_t got, input key_code_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Drives one device frame with a start bit, eight data bits LSB first, odd parity and a stop bit
    task automatic send_frame(input key_code_t data, input logic bad_parity,
                              input logic bad_stop, input logic [3:0] frame_bits);
        logic [10:0] frame;
        logic        parity;
        logic [3:0]  bit_idx;
        parity = ~(^data) ^ bad_parity;
        frame  = {~bad_stop, parity, data, 1'b0};
        for (bit_idx = 4'd0; bit_idx < frame_bits; bit_idx++) begin
            ps2_data = frame[bit_idx];
            step(HALF_BIT / 2);
            ps2_clk = 1'b0;
            step(HALF_BIT);
            ps2_clk = 1'b1;
            step(HALF_BIT / 2);
        end
        ps2_data = 1'b1;
    endtask

    task automatic wait_event(output logic seen);
        int count;
        seen  = 1'b0;
        count = 0;
        while (!seen && count < EVENT_TIMEOUT) begin
            if (key_pending === 1'b1) begin
                seen = 1'b1;
            end else begin
                step(1);
                count++;
            end
        end
    endtask

    task automatic ack_event();
        key_ack = 1'b1;
        step(1);
        key_ack = 1'b0;
        check_flag("key_pending", key_pending, 1'b0);
    endtask

    task automatic check_event(input stim_t row);
        check_code("key_code", key_code, row.exp_code);
        check_flag("key_extended", key_extended, row.exp_ext);
        check_flag("key_released", key_released, row.exp_rel);
    endtask

    task automatic add_row(input int nbytes, input key_code_t b0, input key_code_t b1,
                           input key_code_t b2, input int corrupt, input int raw,
                           input int hold, input int has_event, input key_code_t code,
                           input int ext, input int rel);
        stim_t row;
        row.seq        = {b2, b1, b0};
        row.nbytes     = 2'(nbytes);
        row.bad_parity = (corrupt == BAD_PARITY);
        row.bad_stop   = (corrupt == BAD_STOP);
        row.frame_bits = (corrupt == TRUNCATED) ? 4'd3 : 4'd11;
        row.raw        = (raw != 0);
        row.hold       = (hold != 0);
        row.has_event  = (has_event != 0);
        row.exp_code   = code;
        row.exp_ext    = (ext != 0);
        row.exp_rel    = (rel != 0);
        stim_table.push_back(row);
    endtask

    // Each row gives the byte count, three bytes, damage, raw, hold, event, code, extended
    // and released
    task automatic build_table();
        add_row(1, 8'h1C, 8'h00, 8'h00, OK_FRAME, 0, 0, 1, 8'h1C, 0, 0);
        add_row(2, PREFIX_EXTENDED, 8'h75, 8'h00, OK_FRAME, 0, 0, 1, 8'h75, 1, 0);
        add_row(1, 8'h29, 8'h00, 8'h00, OK_FRAME, 0, 0, 1, 8'h29, 0, 0);
        add_row(2, PREFIX_RELEASE, 8'h1C, 8'h00, OK_FRAME, 0, 0, 1, 8'h1C, 0, 1);
        add_row(3, PREFIX_EXTENDED, PREFIX_RELEASE, 8'h75, OK_FRAME, 0, 0, 1, 8'h75, 1, 1);
        add_row(1, 8'h29, 8'h00, 8'h00, OK_FRAME, 0, 0, 1, 8'h29, 0, 0);
        add_row(1, PREFIX_EXTENDED, 8'h00, 8'h00, OK_FRAME, 1, 0, 1, PREFIX_EXTENDED, 0, 0);
        add_row(1, PREFIX_RELEASE, 8'h00, 8'h00, OK_FRAME, 1, 0, 1, PREFIX_RELEASE, 0, 0);
        add_row(1, 8'h1C, 8'h00, 8'h00, BAD_PARITY, 0, 0, 0, 8'h00, 0, 0);
        add_row(1, 8'h32, 8'h00, 8'h00, OK_FRAME, 0, 0, 1, 8'h32, 0, 0);
        add_row(1, 8'h1C, 8'h00, 8'h00, BAD_STOP, 0, 0, 0, 8'h00, 0, 0);
        add_row(1, 8'h21, 8'h00, 8'h00, OK_FRAME, 0, 0, 1, 8'h21, 0, 0);
        add_row(1, 8'h1C, 8'h00, 8'h00, TRUNCATED, 0, 0, 0, 8'h00, 0, 0);
        add_row(1, 8'h23, 8'h00, 8'h00, OK_FRAME, 0, 0, 1, 8'h23, 0, 0);
        // The decoder holds one byte and the FIFO four more, so the sixth is lost
        add_row(1, 8'h15, 8'h00, 8'h00, OK_FRAME, 0, 1, 1, 8'h15, 0, 0);
        add_row(1, 8'h16, 8'h00, 8'h00, OK_FRAME, 0, 1, 1, 8'h16, 0, 0);
        add_row(1, 8'h1E, 8'h00, 8'h00, OK_FRAME, 0, 1, 1, 8'h1E, 0, 0);
        add_row(1, 8'h26, 8'h00, 8'h00, OK_FRAME, 0, 1, 1, 8'h26, 0, 0);
        add_row(1, 8'h25, 8'h00, 8'h00, OK_FRAME, 0, 1, 1, 8'h25, 0, 0);
        add_row(1, 8'h2E, 8'h00, 8'h00, OK_FRAME, 0, 1, 0, 8'h00, 0, 0);
    endtask

    task automatic run_row(input stim_t row, input int index);
        logic       seen;
        logic [1:0] n;
        raw_mode = row.raw;
        for (n = 2'd0; n < row.nbytes; n++) begin
            send_frame(row.seq[n], row.bad_parity, row.bad_stop, row.frame_bits);
            step(40 + ($random(seed) & 63));
        end
        // A stalled frame must be abandoned before anything else is sent
        if (row.frame_bits != 4'd11) begin
            step(TIMEOUT_CYCLES + 500);
        end
        if (row.hold) begin
            if (row.has_event) begin
                held_rows.push_back(row);
            end
            return;
        end
        wait_event(seen);
        if (row.has_event && !seen) begin
            event_errors++;
            $display("No key event arrived for table row %0d", index);
        end else if (row.has_event) begin
            check_event(row);
            check_flag("overflow", overflow, 1'b0);
            step(HOLD_CYCLES);
            check_flag("key_pending", key_pending, 1'b1);
            check_code("key_code", key_code, row.exp_code);
            ack_event();
        end else if (seen) begin
            event_errors++;
            $display("Table row %0d gave a key event with code %h but should give none",
                     index, key_code);
            ack_event();
        end
    endtask

    // Acknowledges the backed up events one at a time in arrival order
    task automatic drain_held();
        logic  seen;
        stim_t row;
        check_flag("overflow", overflow, 1'b1);
        while (held_rows.size() > 0) begin
            row = held_rows.pop_front();
            wait_event(seen);
            if (!seen) begin
                event_errors++;
                $display("Held byte %h never came out as a key event", row.exp_code);
            end else begin
                check_event(row);
                ack_event();
            end
        end
        wait_event(seen);
        if (seen) begin
            event_errors++;
            $display("Extra key event with code %h after the backlog", key_code);
            ack_event();
        end
    endtask

    initial begin
        seed         = 39257;
        value_errors = 0;
        event_errors = 0;
        rst_n        = 1'b0;
        rx_enable    = 1'b1;
        raw_mode     = 1'b0;
        key_ack      = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        build_table();
        step(8);
        rst_n = 1'b1;
        step(4);
        check_flag("key_pending", key_pending, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        foreach (stim_table[i]) begin
            run_row(stim_table[i], i);
        end
        drain_held();
        $display("Errors: %0d value mismatches, %0d event errors", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
